//--- verilog/ads_scan_pkg.sv
package ads_scan_pkg;

	localparam int BYTE_W         = 8;
	localparam int DEV_ADDR_W     = 7;
	localparam int SAMPLE_W       = 32;
	localparam int ADC_W          = 24;  // raw ADS122C04 code
	localparam int SAMPLE_CREDITS = 2;   // credits held after reset
	localparam int QTICK_BASE     = 4;   // quarter bit = 2^(rate + QTICK_BASE) clocks

	// ADC command bytes
	localparam logic [BYTE_W-1:0] WREG_CONFIG_0  = 8'h40;
	localparam logic [BYTE_W-1:0] CMD_START_CONV = 8'h08;
	localparam logic [BYTE_W-1:0] CMD_RDATA      = 8'h10;

	// config-0 mux codes, AINx against AVSS, indexed by ain_t
	localparam logic [BYTE_W-1:0] MUX_CODE [4] = '{8'h81, 8'h91, 8'hA1, 8'hB1};

	typedef enum logic [2:0] {
		CMD_START, CMD_WRITE, CMD_READ_ACK, CMD_READ_NACK, CMD_STOP
	} i2c_cmd_t;

	typedef enum logic {MODE_HOST_WRITE, MODE_SCAN} scan_mode_t;

	typedef enum logic [1:0] {
		RATE_3125K = 2'd0,
		RATE_1562K = 2'd1,
		RATE_781K  = 2'd2,
		RATE_390K  = 2'd3
	} rate_t;

	typedef enum logic [1:0] {CFG_CTRL, CFG_DEV_ADDR, CFG_REG, CFG_DATA} cfg_sel_t;

	typedef enum logic [1:0] {AIN0, AIN1, AIN2, AIN3} ain_t;

endpackage

//--- verilog/scl_clock_gen.sv
`timescale 1ns/100ps

module scl_clock_gen import ads_scan_pkg::*; (
	input  logic  i2c_clk,
	input  logic  i_rst_n,
	input  rate_t i_rate,
	output logic  o_qtick
);

	localparam int CNT_W = QTICK_BASE + 3; // slowest rate divides by 2^7

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_last;
	rate_t            rate_q; // rate in use until the next wrap

	assign cnt_last = {CNT_W{1'b1}} >> (2'd3 - rate_q);

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt     <= '0;
			rate_q  <= RATE_390K;
			o_qtick <= 1'b0;
		end else if (cnt == cnt_last) begin
			cnt     <= '0;
			rate_q  <= i_rate; // pick up a new rate only here
			o_qtick <= 1'b1;
		end else begin
			cnt     <= cnt + 1'b1;
			o_qtick <= 1'b0;
		end
	end

endmodule

//--- verilog/i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine import ads_scan_pkg::*; (
	input  logic              i2c_clk,
	input  logic              i_rst_n,
	input  logic              i_qtick,
	input  logic              i_cmd_valid,
	input  i2c_cmd_t          i_cmd_op,
	input  logic [BYTE_W-1:0] i_cmd_wbyte,
	input  logic              i_sda,
	output logic              o_cmd_ready,
	output logic              o_cmd_done,
	output logic [BYTE_W-1:0] o_rd_byte,
	output logic              o_ack_err,
	output logic              o_scl_low,
	output logic              o_sda_low
);

	// one state per quarter of a bit slot
	typedef enum logic [2:0] {ENG_IDLE, ENG_Q0, ENG_Q1, ENG_Q2, ENG_Q3} eng_state_t;

	eng_state_t        state;
	i2c_cmd_t          op;
	logic [3:0]        slot;     // bit slot within the command, 8 is the ack slot
	logic [1:0]        sda_sync;
	logic              sda_in;
	logic              data_bit;
	logic              last_slot;
	logic [BYTE_W-1:0] shreg;    // out and in share one shifter

	assign sda_in      = sda_sync[1];
	assign data_bit    = !slot[3] && (op != CMD_START) && (op != CMD_STOP);
	assign last_slot   = (op == CMD_START) || (op == CMD_STOP) || (slot == 4'd8);
	assign o_cmd_ready = (state == ENG_IDLE);
	assign o_rd_byte   = shreg;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], i_sda};
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ENG_IDLE;
			op         <= CMD_STOP;
			slot       <= '0;
			o_scl_low  <= 1'b0;
			o_sda_low  <= 1'b0;
			o_cmd_done <= 1'b0;
			o_ack_err  <= 1'b0;
		end else begin
			o_cmd_done <= 1'b0;
			case (state)
				ENG_IDLE: begin
					if (i_cmd_valid) begin
						op        <= i_cmd_op;
						slot      <= '0;
						o_ack_err <= 1'b0;
						state     <= ENG_Q0;
					end
				end
				ENG_Q0: if (i_qtick) begin // SCL low here, SDA may move
					if (op == CMD_STOP)
						o_sda_low <= 1'b1;
					else if (op == CMD_WRITE && data_bit)
						o_sda_low <= ~shreg[BYTE_W-1];
					else
						o_sda_low <= (op == CMD_READ_ACK) && !data_bit; // master ack
					state <= ENG_Q1;
				end
				ENG_Q1: if (i_qtick) begin
					o_scl_low <= 1'b0; // SCL rises
					state     <= ENG_Q2;
				end
				ENG_Q2: if (i_qtick) begin // middle of SCL high
					if (op == CMD_START)
						o_sda_low <= 1'b1;
					else if (op == CMD_STOP)
						o_sda_low <= 1'b0;
					else if (!data_bit)
						o_ack_err <= (op == CMD_WRITE) && sda_in; // slave left SDA high
					state <= ENG_Q3;
				end
				ENG_Q3: if (i_qtick) begin
					o_scl_low <= (op != CMD_STOP); // bus stays released after stop
					if (last_slot) begin
						o_cmd_done <= 1'b1;
						state      <= ENG_IDLE;
					end else begin
						slot  <= slot + 1'b1;
						state <= ENG_Q0;
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// MSB first, sampled bit enters at the bottom
	always_ff @(posedge i2c_clk) begin
		if (state == ENG_IDLE && i_cmd_valid)
			shreg <= i_cmd_wbyte;
		else if (state == ENG_Q2 && i_qtick && data_bit)
			shreg <= {shreg[BYTE_W-2:0], sda_in};
	end

endmodule

//--- verilog/ads_ctrl_regs.sv
`timescale 1ns/100ps

module ads_ctrl_regs import ads_scan_pkg::*; (
	input  logic                  i2c_clk,
	input  logic                  i_rst_n,
	input  logic                  i_cfg_wr,
	input  cfg_sel_t              i_cfg_sel,
	input  logic [BYTE_W-1:0]     i_cfg_wdata,
	input  logic                  i_go_clear,
	output logic                  o_enable,
	output scan_mode_t            o_mode,
	output rate_t                 o_rate,
	output logic [DEV_ADDR_W-1:0] o_dev_addr,
	output logic [BYTE_W-1:0]     o_reg_byte,
	output logic [BYTE_W-1:0]     o_data_byte
);

	logic  ctrl_wr;
	rate_t rate_dec;

	// ctrl byte layout [0] enable, [1] mode, [4:2] rate select
	assign ctrl_wr = i_cfg_wr && (i_cfg_sel == CFG_CTRL);

	always_comb begin
		case (i_cfg_wdata[4:2])
			3'd0:    rate_dec = RATE_3125K;
			3'd1:    rate_dec = RATE_1562K;
			3'd2:    rate_dec = RATE_781K;
			default: rate_dec = RATE_390K; // slowest for anything else
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_enable <= 1'b0;
			o_mode   <= MODE_HOST_WRITE;
			o_rate   <= RATE_390K;
		end else if (ctrl_wr) begin
			o_enable <= i_cfg_wdata[0];
			o_mode   <= scan_mode_t'(i_cfg_wdata[1]);
			o_rate   <= rate_dec;
		end else if (i_go_clear) begin
			o_enable <= 1'b0; // host write taken, go bit drops
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (i_cfg_wr && i_cfg_sel == CFG_DEV_ADDR) o_dev_addr  <= i_cfg_wdata[DEV_ADDR_W-1:0];
		if (i_cfg_wr && i_cfg_sel == CFG_REG)      o_reg_byte  <= i_cfg_wdata;
		if (i_cfg_wr && i_cfg_sel == CFG_DATA)     o_data_byte <= i_cfg_wdata;
	end

endmodule

//--- verilog/adc_scan_sequencer.sv
`timescale 1ns/100ps

module adc_scan_sequencer import ads_scan_pkg::*; (
	input  logic                       i2c_clk,
	input  logic                       i_rst_n,
	input  logic                       i_enable,
	input  scan_mode_t                 i_mode,
	input  logic [DEV_ADDR_W-1:0]      i_dev_addr,
	input  logic [BYTE_W-1:0]          i_reg_byte,
	input  logic [BYTE_W-1:0]          i_data_byte,
	input  logic                       i_drdy_n,
	input  logic                       i_cmd_ready,
	input  logic                       i_cmd_done,
	input  logic [BYTE_W-1:0]          i_rd_byte,
	input  logic                       i_ack_err,
	input  logic                       i_credit_return,
	output logic                       o_go_clear,
	output logic                       o_cmd_valid,
	output i2c_cmd_t                   o_cmd_op,
	output logic [BYTE_W-1:0]          o_cmd_wbyte,
	output logic                       o_sample_valid,
	output ain_t                       o_sample_chan,
	output logic signed [SAMPLE_W-1:0] o_sample_data,
	output logic                       o_done,
	output logic                       o_ack_err
);

	localparam int CRED_W = $clog2(SAMPLE_CREDITS + 1);

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_START, SEQ_ADDR, SEQ_BYTE1, SEQ_BYTE2, SEQ_READ, SEQ_STOP, SEQ_WAIT_DRDY
	} seq_state_t;

	// which transaction is on the bus
	typedef enum logic [2:0] {PH_HOST, PH_WREG, PH_CONV, PH_RDATA, PH_READ} phase_t;

	seq_state_t       state;
	phase_t           phase;
	ain_t             chan;
	logic             pend;     // command of this state not yet taken
	logic             err;
	logic [1:0]       rd_cnt;
	logic [1:0]       drdy_sync;
	logic [CRED_W-1:0] credits;
	logic [ADC_W-1:0] adc_q;
	logic             emit;

	assign o_cmd_valid = pend && i_cmd_ready;
	assign emit = (state == SEQ_STOP) && i_cmd_done && !err && (phase == PH_READ);

	always_comb begin
		o_cmd_op    = CMD_WRITE;
		o_cmd_wbyte = {i_dev_addr, phase == PH_READ}; // R/W bit
		case (state)
			SEQ_START: o_cmd_op = CMD_START;
			SEQ_STOP:  o_cmd_op = CMD_STOP;
			SEQ_READ:  o_cmd_op = (rd_cnt == 2'd2) ? CMD_READ_NACK : CMD_READ_ACK;
			SEQ_BYTE1: begin
				case (phase)
					PH_HOST: o_cmd_wbyte = i_reg_byte;
					PH_WREG: o_cmd_wbyte = WREG_CONFIG_0;
					PH_CONV: o_cmd_wbyte = CMD_START_CONV;
					default: o_cmd_wbyte = CMD_RDATA;
				endcase
			end
			SEQ_BYTE2: o_cmd_wbyte = (phase == PH_HOST) ? i_data_byte : MUX_CODE[chan];
			default: ;
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			drdy_sync <= 2'b11;
		end else begin
			drdy_sync <= {drdy_sync[0], i_drdy_n};
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= SEQ_IDLE;
			phase <= PH_HOST;
			chan <= AIN0;
			pend <= 1'b0;
			err <= 1'b0;
			rd_cnt <= '0;
			o_go_clear <= 1'b0;
			o_done <= 1'b0;
			o_ack_err <= 1'b0;
			o_sample_valid <= 1'b0;
		end else begin
			o_go_clear <= 1'b0;
			o_done <= 1'b0;
			o_ack_err <= 1'b0;
			o_sample_valid <= emit;
			if (o_cmd_valid)
				pend <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					err <= 1'b0;
					if (i_enable && i_mode == MODE_HOST_WRITE) begin
						phase <= PH_HOST;
						o_go_clear <= 1'b1;
						pend <= 1'b1;
						state <= SEQ_START;
					end else if (i_enable && credits != '0) begin // next channel needs a credit
						phase <= PH_WREG;
						pend <= 1'b1;
						state <= SEQ_START;
					end
				end
				SEQ_START: if (i_cmd_done) begin
					pend <= 1'b1;
					state <= SEQ_ADDR;
				end
				SEQ_ADDR: if (i_cmd_done) begin
					pend <= 1'b1;
					rd_cnt <= '0;
					err <= i_ack_err;
					if (i_ack_err)
						state <= SEQ_STOP;
					else
						state <= (phase == PH_READ) ? SEQ_READ : SEQ_BYTE1;
				end
				SEQ_BYTE1: if (i_cmd_done) begin
					pend <= 1'b1;
					err <= i_ack_err;
					if (i_ack_err || phase == PH_CONV || phase == PH_RDATA)
						state <= SEQ_STOP; // single command byte
					else
						state <= SEQ_BYTE2;
				end
				SEQ_BYTE2: if (i_cmd_done) begin
					pend <= 1'b1;
					err <= i_ack_err;
					state <= SEQ_STOP;
				end
				SEQ_READ: if (i_cmd_done) begin
					pend <= 1'b1;
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == 2'd2)
						state <= SEQ_STOP;
				end
				SEQ_STOP: if (i_cmd_done) begin
					state <= SEQ_IDLE;
					if (err) begin
						o_ack_err <= 1'b1; // scan retries this channel
					end else begin
						case (phase)
							PH_HOST: o_done <= 1'b1;
							PH_WREG: begin
								phase <= PH_CONV;
								pend <= 1'b1;
								state <= SEQ_START;
							end
							PH_CONV: begin
								phase <= PH_RDATA;
								state <= SEQ_WAIT_DRDY;
							end
							PH_RDATA: begin
								phase <= PH_READ;
								pend <= 1'b1;
								state <= SEQ_START;
							end
							default: chan <= ain_t'(chan + 2'd1); // wraps AIN3 to AIN0
						endcase
					end
				end
				SEQ_WAIT_DRDY: if (!drdy_sync[1]) begin
					pend <= 1'b1;
					state <= SEQ_START;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			credits <= CRED_W'(SAMPLE_CREDITS);
		else if (i_credit_return && !emit && credits != CRED_W'(SAMPLE_CREDITS))
			credits <= credits + 1'b1;
		else if (!i_credit_return && emit)
			credits <= credits - 1'b1;
	end

	always_ff @(posedge i2c_clk) begin
		if (state == SEQ_READ && i_cmd_done)
			adc_q <= {adc_q[ADC_W-BYTE_W-1:0], i_rd_byte}; // msb byte first
		if (emit) begin
			o_sample_chan <= chan;
			o_sample_data <= {{(SAMPLE_W-ADC_W){adc_q[ADC_W-1]}}, adc_q};
		end
	end

endmodule

//--- verilog/ads_scan_top.sv
`timescale 1ns/100ps

module ads_scan_top import ads_scan_pkg::*; (
	input  logic                       i2c_clk,
	input  logic                       i_rst_n,
	input  logic                       i_cfg_wr,
	input  cfg_sel_t                   i_cfg_sel,
	input  logic [BYTE_W-1:0]          i_cfg_wdata,
	input  logic                       i_drdy_n,
	input  logic                       i_sda,
	input  logic                       i_credit_return,
	output logic                       o_scl_low,
	output logic                       o_sda_low,
	output logic                       o_sample_valid,
	output ain_t                       o_sample_chan,
	output logic signed [SAMPLE_W-1:0] o_sample_data,
	output logic                       o_done,
	output logic                       o_ack_err
);

	logic                  enable, go_clear, qtick;
	scan_mode_t            mode;
	rate_t                 rate;
	logic [DEV_ADDR_W-1:0] dev_addr;
	logic [BYTE_W-1:0]     reg_byte, data_byte;
	logic                  cmd_valid, cmd_ready, cmd_done, eng_ack_err;
	i2c_cmd_t              cmd_op;
	logic [BYTE_W-1:0]     cmd_wbyte, rd_byte;

	ads_ctrl_regs regs0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_cfg_wr(i_cfg_wr), .i_cfg_sel(i_cfg_sel),
		.i_cfg_wdata(i_cfg_wdata), .i_go_clear(go_clear), .o_enable(enable), .o_mode(mode),
		.o_rate(rate), .o_dev_addr(dev_addr), .o_reg_byte(reg_byte), .o_data_byte(data_byte)
	);

	scl_clock_gen clkgen0 (.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_rate(rate), .o_qtick(qtick));

	i2c_byte_engine eng0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_qtick(qtick), .i_cmd_valid(cmd_valid),
		.i_cmd_op(cmd_op), .i_cmd_wbyte(cmd_wbyte), .i_sda(i_sda), .o_cmd_ready(cmd_ready),
		.o_cmd_done(cmd_done), .o_rd_byte(rd_byte), .o_ack_err(eng_ack_err),
		.o_scl_low(o_scl_low), .o_sda_low(o_sda_low)
	);

	adc_scan_sequencer seq0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_enable(enable), .i_mode(mode),
		.i_dev_addr(dev_addr), .i_reg_byte(reg_byte), .i_data_byte(data_byte),
		.i_drdy_n(i_drdy_n), .i_cmd_ready(cmd_ready), .i_cmd_done(cmd_done),
		.i_rd_byte(rd_byte), .i_ack_err(eng_ack_err), .i_credit_return(i_credit_return),
		.o_go_clear(go_clear), .o_cmd_valid(cmd_valid), .o_cmd_op(cmd_op),
		.o_cmd_wbyte(cmd_wbyte), .o_sample_valid(o_sample_valid), .o_sample_chan(o_sample_chan),
		.o_sample_data(o_sample_data), .o_done(o_done), .o_ack_err(o_ack_err)
	);

endmodule

//--- verification/ads_i2c_slave_model.sv
`timescale 1ns/100ps

module ads_i2c_slave_model import ads_scan_pkg::*; (
	input  logic                   i2c_clk,
	input  logic                   i_rst_n,
	input  logic                   i_scl_low,
	input  logic                   i_sda_low,
	input  logic [DEV_ADDR_W-1:0]  i_addr,
	input  logic [4*ADC_W-1:0]     i_codes,
	output logic                   o_sda,
	output logic                   o_drdy_n,
	output logic                   o_wr_valid,
	output logic [BYTE_W-1:0]      o_wr_byte
);

	logic              scl;
	logic              scl_q;
	logic              sda_q;
	logic              slave_low;
	logic              active;  // addressed, or waiting for the address byte
	logic              first;   // next byte is the address
	logic              tx;
	logic              tx_next;
	logic              last40;  // previous byte was the config-0 write
	logic [3:0]        bitcnt;
	logic [3:0]        drdy_cnt;
	logic [1:0]        rd_idx;
	logic [1:0]        chan;
	logic [BYTE_W-1:0] shreg;
	logic [BYTE_W-1:0] txb;
	logic [ADC_W-1:0]  code;

	assign scl   = !i_scl_low;
	assign o_sda = !(i_sda_low || slave_low); // wired-AND bus
	assign code  = i_codes[chan*ADC_W +: ADC_W];

	always @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			slave_low <= 1'b0;
			active <= 1'b0;
			first <= 1'b0;
			tx <= 1'b0;
			tx_next <= 1'b0;
			last40 <= 1'b0;
			bitcnt <= '0;
			drdy_cnt <= '0;
			rd_idx <= '0;
			chan <= '0;
			o_drdy_n <= 1'b1;
			o_wr_valid <= 1'b0;
		end else begin
			scl_q <= scl;
			sda_q <= o_sda;
			o_wr_valid <= 1'b0;
			if (drdy_cnt != 4'd0) begin
				drdy_cnt <= drdy_cnt - 4'd1;
				if (drdy_cnt == 4'd1)
					o_drdy_n <= 1'b0; // conversion ready
			end
			if (scl_q && scl && sda_q && !o_sda) begin // start
				active <= 1'b1;
				first <= 1'b1;
				tx <= 1'b0;
				tx_next <= 1'b0;
				bitcnt <= '0;
			end else if (scl_q && scl && !sda_q && o_sda) begin // stop
				active <= 1'b0;
				slave_low <= 1'b0;
			end else if (active && !scl_q && scl) begin
				if (bitcnt != 4'd8) begin
					shreg <= {shreg[BYTE_W-2:0], o_sda};
					bitcnt <= bitcnt + 4'd1;
				end else begin
					bitcnt <= '0;
					tx_next <= 1'b0;
					if (tx_next)
						tx <= 1'b1;
					if (tx && o_sda) begin // master nack ends the read
						tx <= 1'b0;
						o_drdy_n <= 1'b1;
					end else if (tx) begin
						txb <= (rd_idx == 2'd1) ? code[15:8] : code[7:0];
						rd_idx <= rd_idx + 2'd1;
					end
				end
			end else if (active && scl_q && !scl) begin
				if (bitcnt == 4'd8 && tx) begin
					slave_low <= 1'b0; // master drives ack
				end else if (bitcnt == 4'd8 && first) begin
					first <= 1'b0;
					if (shreg[7:1] == i_addr) begin
						slave_low <= 1'b1;
						o_wr_valid <= 1'b1;
						o_wr_byte <= shreg;
						tx_next <= shreg[0];
						txb <= code[23:16];
						rd_idx <= 2'd1;
					end else begin
						active <= 1'b0; // not ours, no ack
					end
				end else if (bitcnt == 4'd8) begin
					slave_low <= 1'b1;
					o_wr_valid <= 1'b1;
					o_wr_byte <= shreg;
					last40 <= (shreg == WREG_CONFIG_0);
					if (last40)
						chan <= shreg[5:4]; // mux code picks the channel
					if (shreg == CMD_START_CONV)
						drdy_cnt <= 4'd10;
				end else if (tx) begin
					slave_low <= !txb[3'd7 - bitcnt[2:0]];
				end else begin
					slave_low <= 1'b0;
				end
			end
		end
	end

endmodule

//--- verification/ads_scan_tb.sv
`timescale 1ns/100ps

module ads_scan_tb import ads_scan_pkg::*; ();

	localparam int N_STEPS    = 7;
	localparam int HOST_SLOTS = 29;  // start, three bytes, stop
	localparam int CHAN_SLOTS = 107; // four transactions per channel

	typedef struct {
		scan_mode_t            mode;
		rate_t                 rate;
		logic [DEV_ADDR_W-1:0] dev_addr;
		logic [DEV_ADDR_W-1:0] slave_addr;
		logic [BYTE_W-1:0]     reg_b;
		logic [BYTE_W-1:0]     data_b;
		logic [3:0][ADC_W-1:0] codes;
		bit                    hold;     // withhold credit returns
		int                    n_samples;
		bit                    exp_err;
	} step_t;

	logic                       i2c_clk;
	logic                       i_rst_n;
	logic                       i_cfg_wr;
	cfg_sel_t                   i_cfg_sel;
	logic [BYTE_W-1:0]          i_cfg_wdata;
	logic                       i_drdy_n;
	logic                       i_sda;
	logic                       i_credit_return;
	logic                       o_scl_low;
	logic                       o_sda_low;
	logic                       o_sample_valid;
	ain_t                       o_sample_chan;
	logic signed [SAMPLE_W-1:0] o_sample_data;
	logic                       o_done;
	logic                       o_ack_err;

	step_t                      steps [N_STEPS];
	int                         seed = 254;
	longint                     cyc = 0;
	longint                     limit = 64'h7fff_ffff_ffff;
	ain_t                       chan_q [$];
	logic signed [SAMPLE_W-1:0] data_q [$];
	logic [BYTE_W-1:0]          wr_q [$];
	longint                     fall_q [$];
	int                         done_cnt;
	int                         err_cnt;
	bit                         hold_now;
	bit                         manual_credit;
	logic                       scl_low_q;
	logic [DEV_ADDR_W-1:0]      slave_addr;
	logic [4*ADC_W-1:0]         slave_codes;
	logic                       wr_valid;
	logic [BYTE_W-1:0]          wr_byte;

	ads_scan_top dut0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_cfg_wr(i_cfg_wr), .i_cfg_sel(i_cfg_sel),
		.i_cfg_wdata(i_cfg_wdata), .i_drdy_n(i_drdy_n), .i_sda(i_sda),
		.i_credit_return(i_credit_return), .o_scl_low(o_scl_low), .o_sda_low(o_sda_low),
		.o_sample_valid(o_sample_valid), .o_sample_chan(o_sample_chan),
		.o_sample_data(o_sample_data), .o_done(o_done), .o_ack_err(o_ack_err)
	);

	ads_i2c_slave_model slave0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_scl_low(o_scl_low), .i_sda_low(o_sda_low),
		.i_addr(slave_addr), .i_codes(slave_codes), .o_sda(i_sda), .o_drdy_n(i_drdy_n),
		.o_wr_valid(wr_valid), .o_wr_byte(wr_byte)
	);

	initial begin
		i2c_clk = 1'b0;
		forever #50 i2c_clk = ~i2c_clk;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string what, input logic [BYTE_W-1:0] got,
			input logic [BYTE_W-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("ERR %0t: %s got %02h expected %02h", $time, what, got, exp));
	endtask

	task automatic check_sample(input int idx, input ain_t got_chan,
			input logic signed [SAMPLE_W-1:0] got_data, input ain_t exp_chan,
			input logic signed [SAMPLE_W-1:0] exp_data);
		if (got_chan !== exp_chan || got_data !== exp_data)
			stop_run($sformatf("ERR %0t: sample %0d got %s %08h expected %s %08h", $time,
				idx, got_chan.name(), got_data, exp_chan.name(), exp_data));
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		if (got !== exp)
			stop_run($sformatf("ERR %0t: %s is %0b expected %0b", $time, what, got, exp));
	endtask

	function automatic logic signed [SAMPLE_W-1:0] sign_extend(input logic [ADC_W-1:0] c);
		logic signed [SAMPLE_W-1:0] v;
		v = SAMPLE_W'(c);
		if (c[ADC_W-1])
			v = v - (SAMPLE_W'(1) << ADC_W); // negative code sits 2^24 below its raw value
		return v;
	endfunction

	function automatic longint quarter_clocks(input rate_t r);
		return longint'(1) << (int'(r) + QTICK_BASE);
	endfunction

	// monitor sees the values from before this edge
	always @(posedge i2c_clk) begin
		cyc = cyc + 1;
		if (cyc > limit)
			stop_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
		if (!i_rst_n) begin
			chan_q.delete();
			data_q.delete();
			wr_q.delete();
			fall_q.delete();
			done_cnt = 0;
			err_cnt = 0;
			scl_low_q = 1'b0;
			i_credit_return <= 1'b0;
		end else begin
			if (o_sample_valid) begin
				chan_q.push_back(o_sample_chan);
				data_q.push_back(o_sample_data);
			end
			i_credit_return <= (o_sample_valid && !hold_now) || manual_credit;
			manual_credit = 1'b0;
			if (o_done)
				done_cnt = done_cnt + 1;
			if (o_ack_err)
				err_cnt = err_cnt + 1;
			if (wr_valid)
				wr_q.push_back(wr_byte);
			if (o_scl_low && !scl_low_q)
				fall_q.push_back(cyc); // scl falling edge
			scl_low_q = o_scl_low;
		end
	end

	task automatic apply_reset();
		i_rst_n <= 1'b0;
		repeat (8) @(posedge i2c_clk);
		i_rst_n <= 1'b1;
		@(posedge i2c_clk);
	endtask

	task automatic cfg_write(input cfg_sel_t sel, input logic [BYTE_W-1:0] data);
		@(posedge i2c_clk);
		i_cfg_wr <= 1'b1;
		i_cfg_sel <= sel;
		i_cfg_wdata <= data;
		@(posedge i2c_clk);
		i_cfg_wr <= 1'b0;
	endtask

	task automatic build_table();
		for (int i = 0; i < N_STEPS; i++) begin
			steps[i].mode = (i == 4 || i == 5) ? MODE_SCAN : MODE_HOST_WRITE;
			steps[i].rate = (i < 4) ? rate_t'(2'(i)) : ((i == 5) ? RATE_1562K : RATE_3125K);
			steps[i].dev_addr = 7'h40;
			steps[i].slave_addr = (i == 6) ? 7'h45 : 7'h40; // last step misses the slave
			steps[i].reg_b = 8'($random(seed));
			steps[i].data_b = 8'($random(seed));
			for (int k = 0; k < 4; k++)
				steps[i].codes[k] = 24'($random(seed));
			steps[i].hold = (i == 5);
			steps[i].n_samples = (i == 4) ? 5 : ((i == 5) ? SAMPLE_CREDITS : 0);
			steps[i].exp_err = (i == 6);
		end
	endtask

	task automatic run_host(input step_t st);
		longint per;
		per = 4 * quarter_clocks(st.rate);
		if (st.exp_err) begin
			while (err_cnt == 0)
				@(posedge i2c_clk);
			@(posedge i2c_clk);
			check_flag("scl released", o_scl_low, 1'b0);
			check_flag("sda released", o_sda_low, 1'b0);
			repeat (HOST_SLOTS * per) @(posedge i2c_clk);
			check_flag("single ack error", err_cnt == 1, 1'b1);
			check_flag("no done", done_cnt == 0, 1'b1);
			check_flag("no sample", chan_q.size() == 0, 1'b1);
			check_flag("slave took nothing", wr_q.size() == 0, 1'b1);
		end else begin
			while (done_cnt == 0)
				@(posedge i2c_clk);
			repeat (4) @(posedge i2c_clk);
			check_flag("single done", done_cnt == 1, 1'b1);
			check_flag("no ack error", err_cnt == 0, 1'b1);
			check_flag("three bytes", wr_q.size() == 3, 1'b1);
			check_byte("address byte", wr_q[0], {st.dev_addr, 1'b0});
			check_byte("register byte", wr_q[1], st.reg_b);
			check_byte("data byte", wr_q[2], st.data_b);
			for (int k = 1; k < 9; k++)
				check_flag($sformatf("scl period %0d", fall_q[k+1] - fall_q[k]),
					(fall_q[k+1] - fall_q[k]) == per, 1'b1);
		end
	endtask

	task automatic check_channel_bytes(input step_t st, input int n);
		int b;
		for (int i = 0; i < n; i++) begin
			b = 8 * i;
			check_byte("wreg address", wr_q[b], {st.dev_addr, 1'b0});
			check_byte("wreg command", wr_q[b+1], WREG_CONFIG_0);
			check_byte("mux code", wr_q[b+2], MUX_CODE[i % 4]);
			check_byte("start address", wr_q[b+3], {st.dev_addr, 1'b0});
			check_byte("start command", wr_q[b+4], CMD_START_CONV);
			check_byte("rdata address", wr_q[b+5], {st.dev_addr, 1'b0});
			check_byte("rdata command", wr_q[b+6], CMD_RDATA);
			check_byte("read address", wr_q[b+7], {st.dev_addr, 1'b1});
		end
	endtask

	task automatic run_scan(input step_t st);
		while (chan_q.size() < st.n_samples)
			@(posedge i2c_clk);
		if (st.hold) begin
			// two channel times without any credit back
			repeat (2 * CHAN_SLOTS * 4 * quarter_clocks(st.rate)) @(posedge i2c_clk);
			check_flag("samples held", chan_q.size() == SAMPLE_CREDITS, 1'b1);
			check_flag("scl idle", o_scl_low, 1'b0);
			check_flag("sda idle", o_sda_low, 1'b0);
			manual_credit = 1'b1;
			while (chan_q.size() < SAMPLE_CREDITS + 1)
				@(posedge i2c_clk);
		end
		for (int i = 0; i < chan_q.size() && i <= st.n_samples; i++)
			check_sample(i, chan_q[i], data_q[i], ain_t'(2'(i)), sign_extend(st.codes[i % 4]));
		check_channel_bytes(st, chan_q.size());
		check_flag("no ack error", err_cnt == 0, 1'b1);
	endtask

	initial begin
		longint sum;
		i_rst_n = 1'b0;
		i_cfg_wr = 1'b0;
		i_cfg_sel = CFG_CTRL;
		i_cfg_wdata = '0;
		i_credit_return = 1'b0;
		hold_now = 1'b0;
		manual_credit = 1'b0;
		slave_addr = '0;
		slave_codes = '0;
		build_table();
		sum = 0;
		for (int i = 0; i < N_STEPS; i++) begin
			if (steps[i].mode == MODE_HOST_WRITE)
				sum += HOST_SLOTS * 4 * quarter_clocks(steps[i].rate);
			else if (steps[i].hold)
				sum += (SAMPLE_CREDITS + 3) * CHAN_SLOTS * 4 * quarter_clocks(steps[i].rate);
			else
				sum += (steps[i].n_samples + 1) * CHAN_SLOTS * 4 * quarter_clocks(steps[i].rate);
		end
		limit = 2 * sum;
		for (int s = 0; s < N_STEPS; s++) begin
			hold_now = steps[s].hold;
			slave_addr = steps[s].slave_addr;
			slave_codes = steps[s].codes;
			apply_reset();
			check_flag("reset scl_low", o_scl_low, 1'b0);
			check_flag("reset sda_low", o_sda_low, 1'b0);
			check_flag("reset sample_valid", o_sample_valid, 1'b0);
			check_flag("reset done", o_done, 1'b0);
			check_flag("reset ack_err", o_ack_err, 1'b0);
			cfg_write(CFG_DEV_ADDR, {1'b0, steps[s].dev_addr});
			cfg_write(CFG_REG, steps[s].reg_b);
			cfg_write(CFG_DATA, steps[s].data_b);
			cfg_write(CFG_CTRL, {3'b000, 1'b0, steps[s].rate, steps[s].mode, 1'b1});
			if (steps[s].mode == MODE_HOST_WRITE)
				run_host(steps[s]);
			else
				run_scan(steps[s]);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- ads_scan.f
verilog/ads_scan_pkg.sv
verilog/scl_clock_gen.sv
verilog/i2c_byte_engine.sv
verilog/ads_ctrl_regs.sv
verilog/adc_scan_sequencer.sv
verilog/ads_scan_top.sv
verification/ads_i2c_slave_model.sv
verification/ads_scan_tb.sv

//--- Makefile
TOP      ?= ads_scan_tb
SIM      ?= verilator
FILELIST ?= ads_scan.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing -Wno-fatal
PASS_STR ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the printed result line only
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
